//--- design/ntm_config_pkg.sv
// Default operand width, element counter width and lane count for the vector divider

package ntm_config_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Datapath widths
  ////////////////////////////////////////////////////////////////////////////

  // Operand, modulus and result width
  localparam int DEFAULT_DATA_SIZE = 16;

  // Element counter width, bounds the job length
  localparam int DEFAULT_INDEX_SIZE = 8;

  ////////////////////////////////////////////////////////////////////////////
  // Parallelism
  ////////////////////////////////////////////////////////////////////////////

  // Scalar divider lanes behind the dispatcher
  // Elements in flight at most equals this
  localparam int DEFAULT_LANES = 4;

endpackage

//--- design/ntm_state_pkg.sv
// State encodings for the dispatcher, collector and scalar divider FSMs

package ntm_state_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Dispatcher
  ////////////////////////////////////////////////////////////////////////////

  // Waiting for start, collecting a pair, holding a pair for its lane
  typedef enum logic [1:0] {
    DISP_IDLE,
    DISP_INPUT,
    DISP_ISSUE
  } dispatcher_state_e;

  ////////////////////////////////////////////////////////////////////////////
  // Collector
  ////////////////////////////////////////////////////////////////////////////

  // Idle between jobs, draining lanes in order
  typedef enum logic [0:0] {
    COLL_IDLE,
    COLL_DRAIN
  } collector_state_e;

  ////////////////////////////////////////////////////////////////////////////
  // Scalar divider lane
  ////////////////////////////////////////////////////////////////////////////

  // Quotient steps, modulo steps, result held for the collector
  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_DIVIDE,
    DIV_REDUCE,
    DIV_DONE
  } divider_state_e;

endpackage

//--- design/lane_if.sv
// Interface between dispatcher, one scalar divider lane and the collector

`timescale 1ns/10ps

interface lane_if #(
  parameter int DATA_SIZE = ntm_config_pkg::DEFAULT_DATA_SIZE
);

  // Request, from the dispatcher
  // Operands only meaningful in the start cycle
  logic                 start;
  logic [DATA_SIZE-1:0] a;
  logic [DATA_SIZE-1:0] b;
  logic [DATA_SIZE-1:0] modulo;

  // Status and result, from the lane
  logic                 busy;
  logic                 done;
  logic [DATA_SIZE-1:0] result;

  // Result consumed, from the collector
  logic                 take;

  // Issue side sees only busy
  modport dispatcher (
    output start, a, b, modulo,
    input  busy
  );

  modport lane (
    input  start, a, b, modulo, take,
    output busy, done, result
  );

  // Drain side
  modport collector (
    input  done, result,
    output take
  );

endinterface

//--- design/ntm_scalar_divider.sv
// Scalar lane: bit-serial restoring divide of b by a, then serial reduction modulo m

`timescale 1ns/10ps

module ntm_scalar_divider #(
  parameter int DATA_SIZE = ntm_config_pkg::DEFAULT_DATA_SIZE
) (
  input logic   CLK,
  input logic   RST,
  lane_if.lane  lane
);

  import ntm_state_pkg::*;

  // Step counter covers DATA_SIZE steps per phase
  localparam int CNT_W = $clog2(DATA_SIZE + 1);
  localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(DATA_SIZE - 1);

  ////////////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////////////

  divider_state_e state;
  logic [CNT_W-1:0] step_cnt;
  logic busy;
  logic done;

  // Operands latched at start
  logic [DATA_SIZE-1:0] divisor;
  logic [DATA_SIZE-1:0] modulus;

  // Quotient shifts in from the right while the dividend shifts out
  logic [DATA_SIZE-1:0] quo;
  logic [DATA_SIZE-1:0] rem;

  // Modulus aligned to the current reduction bit
  logic [2*DATA_SIZE-1:0] mod_shift;

  logic [DATA_SIZE-1:0] result;

  // Trial subtraction
  logic [DATA_SIZE:0]   rem_shift;
  logic [DATA_SIZE+1:0] diff;

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  // start -> done takes 2*DATA_SIZE+2 cycles
  // One load edge, DATA_SIZE divide edges, DATA_SIZE reduce edges, one output edge
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= DIV_IDLE;
      step_cnt <= '0;
      busy     <= 1'b0;
      done     <= 1'b0;
    end else begin
      case (state)
        DIV_IDLE: begin
          if (lane.start) begin
            busy     <= 1'b1;
            step_cnt <= '0;
            state    <= DIV_DIVIDE;
          end
        end
        DIV_DIVIDE, DIV_REDUCE: begin
          if (step_cnt == LAST_STEP) begin
            step_cnt <= '0;
            state    <= (state == DIV_DIVIDE) ? DIV_REDUCE : DIV_DONE;
          end else begin
            step_cnt <= step_cnt + 1'b1;
          end
        end
        DIV_DONE: begin
          // First DONE cycle registers the result
          if (!done) begin
            done <= 1'b1;
          end else if (lane.take) begin
            done  <= 1'b0;
            busy  <= 1'b0;
            state <= DIV_IDLE;
          end
        end
        default: state <= DIV_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // Partial remainder shifted left, next dividend bit in
    rem_shift = {rem, quo[DATA_SIZE-1]};
    // Sign bit set means the divisor does not fit
    diff      = {1'b0, rem_shift} - {2'b00, divisor};
  end

  always_ff @(posedge CLK) begin
    case (state)
      DIV_IDLE: begin
        if (lane.start) begin
          divisor <= lane.a;
          modulus <= lane.modulo;
          quo     <= lane.b;
          rem     <= '0;
        end
      end
      DIV_DIVIDE: begin
        // Restore on negative trial
        if (diff[DATA_SIZE+1]) begin
          rem <= rem_shift[DATA_SIZE-1:0];
          quo <= {quo[DATA_SIZE-2:0], 1'b0};
        end else begin
          rem <= diff[DATA_SIZE-1:0];
          quo <= {quo[DATA_SIZE-2:0], 1'b1};
        end
        // m << (DATA_SIZE-1) for the first reduction step
        if (step_cnt == LAST_STEP)
          mod_shift <= {1'b0, modulus, {(DATA_SIZE-1){1'b0}}};
      end
      DIV_REDUCE: begin
        // Subtract m << k when it fits, k counting down
        // A zero modulus subtracts nothing
        if ({{DATA_SIZE{1'b0}}, quo} >= mod_shift)
          quo <= quo - mod_shift[DATA_SIZE-1:0];
        mod_shift <= mod_shift >> 1;
      end
      DIV_DONE: begin
        // Zero divisor leaves an all-ones quotient, forced to zero here
        if (!done)
          result <= (divisor == '0) ? '0 : quo;
      end
      default: ;
    endcase
  end

  assign lane.busy   = busy;
  assign lane.done   = done;
  assign lane.result = result;

endmodule

//--- design/ntm_vector_dispatcher.sv
// Job control, operand pair capture and round-robin issue to the divider lanes

`timescale 1ns/10ps

module ntm_vector_dispatcher #(
  parameter int DATA_SIZE  = ntm_config_pkg::DEFAULT_DATA_SIZE,
  parameter int INDEX_SIZE = ntm_config_pkg::DEFAULT_INDEX_SIZE,
  parameter int LANES      = ntm_config_pkg::DEFAULT_LANES
) (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  start,
  input  logic [INDEX_SIZE-1:0] size_in,
  input  logic [DATA_SIZE-1:0]  modulo_in,
  input  logic [DATA_SIZE-1:0]  data_a_in,
  input  logic                  data_a_in_enable,
  input  logic [DATA_SIZE-1:0]  data_b_in,
  input  logic                  data_b_in_enable,
  output logic                  in_ready,
  output logic                  job_start,
  output logic [INDEX_SIZE-1:0] job_size,
  lane_if.dispatcher            lanes [LANES]
);

  import ntm_state_pkg::*;

  localparam int PTR_W = (LANES > 1) ? $clog2(LANES) : 1;

  dispatcher_state_e state;
  logic [PTR_W-1:0] ptr;
  logic [INDEX_SIZE-1:0] issue_cnt;
  logic [LANES-1:0] start_q;
  logic [LANES-1:0] busy_vec;

  // Pair being collected
  logic have_a;
  logic have_b;
  logic [DATA_SIZE-1:0] hold_a;
  logic [DATA_SIZE-1:0] hold_b;

  // Broadcast to every lane, valid with its start
  logic [DATA_SIZE-1:0] iss_a;
  logic [DATA_SIZE-1:0] iss_b;
  logic [DATA_SIZE-1:0] iss_mod;

  logic lane_blocked;
  logic last_issue;
  logic all_idle;
  logic issue;
  logic take_a;
  logic take_b;
  logic have_a_n;
  logic have_b_n;

  ////////////////////////////////////////////////////////////////////////////
  // Lane fan-out
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < LANES; i++) begin : g_lane
    assign busy_vec[i]     = lanes[i].busy;
    assign lanes[i].start  = start_q[i];
    assign lanes[i].a      = iss_a;
    assign lanes[i].b      = iss_b;
    assign lanes[i].modulo = iss_mod;
  end

  // Target lane still working, or just started and not yet busy
  assign lane_blocked = busy_vec[ptr] | start_q[ptr];
  assign last_issue   = (issue_cnt == job_size - INDEX_SIZE'(1));
  // No job active until every lane has handed back its result
  assign all_idle     = ~(|busy_vec) & ~(|start_q);
  assign issue        = (state == DISP_ISSUE) & ~lane_blocked;

  // Refuse operands while a held pair waits, and after the last pair
  assign in_ready = (state == DISP_INPUT) |
                    ((state == DISP_ISSUE) & ~lane_blocked & ~last_issue);

  assign take_a   = in_ready & data_a_in_enable;
  assign take_b   = in_ready & data_b_in_enable;
  assign have_a_n = take_a | (have_a & ~issue);
  assign have_b_n = take_b | (have_b & ~issue);

  ////////////////////////////////////////////////////////////////////////////
  // Job and issue control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= DISP_IDLE;
      ptr       <= '0;
      issue_cnt <= '0;
      start_q   <= '0;
      have_a    <= 1'b0;
      have_b    <= 1'b0;
      job_start <= 1'b0;
      job_size  <= '0;
    end else begin
      start_q   <= '0;
      job_start <= 1'b0;
      have_a    <= have_a_n;
      have_b    <= have_b_n;
      case (state)
        DISP_IDLE: begin
          if (start && all_idle) begin
            // Zero-length job runs one element
            job_size  <= (size_in == '0) ? INDEX_SIZE'(1) : size_in;
            issue_cnt <= '0;
            ptr       <= '0;
            job_start <= 1'b1;
            state     <= DISP_INPUT;
          end
        end
        DISP_INPUT: begin
          if (have_a_n && have_b_n)
            state <= DISP_ISSUE;
        end
        DISP_ISSUE: begin
          if (issue) begin
            start_q[ptr] <= 1'b1;
            ptr          <= (ptr == PTR_W'(LANES - 1)) ? '0 : ptr + 1'b1;
            issue_cnt    <= issue_cnt + 1'b1;
            // A fresh pair may complete on the issue edge itself
            if (last_issue)
              state <= DISP_IDLE;
            else if (have_a_n && have_b_n)
              state <= DISP_ISSUE;
            else
              state <= DISP_INPUT;
          end
        end
        default: state <= DISP_IDLE;
      endcase
    end
  end

  // Operand registers
  always_ff @(posedge CLK) begin
    if (take_a)
      hold_a <= data_a_in;
    if (take_b)
      hold_b <= data_b_in;
    // Modulus sampled at issue
    if (issue) begin
      iss_a   <= hold_a;
      iss_b   <= hold_b;
      iss_mod <= modulo_in;
    end
  end

endmodule

//--- design/ntm_vector_collector.sv
// In-order result draining from the lanes, output enable and job-done pulse

`timescale 1ns/10ps

module ntm_vector_collector #(
  parameter int DATA_SIZE  = ntm_config_pkg::DEFAULT_DATA_SIZE,
  parameter int INDEX_SIZE = ntm_config_pkg::DEFAULT_INDEX_SIZE,
  parameter int LANES      = ntm_config_pkg::DEFAULT_LANES
) (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  job_start,
  input  logic [INDEX_SIZE-1:0] job_size,
  lane_if.collector             lanes [LANES],
  output logic [DATA_SIZE-1:0]  data_out,
  output logic                  data_out_enable,
  output logic                  ready
);

  import ntm_state_pkg::*;

  localparam int PTR_W = (LANES > 1) ? $clog2(LANES) : 1;

  collector_state_e state;
  logic [PTR_W-1:0] ptr;
  logic [INDEX_SIZE-1:0] out_cnt;
  logic [LANES-1:0] take_q;

  logic [LANES-1:0] done_vec;
  logic [DATA_SIZE-1:0] result_arr [LANES];

  // Expected lane has a result not yet taken
  logic hit;

  ////////////////////////////////////////////////////////////////////////////
  // Lane fan-in
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < LANES; i++) begin : g_lane
    assign done_vec[i]   = lanes[i].done;
    assign result_arr[i] = lanes[i].result;
    assign lanes[i].take = take_q[i];
  end

  // done stays up during the take cycle, so mask the lane being taken
  assign hit = (state == COLL_DRAIN) & done_vec[ptr] & ~take_q[ptr];

  ////////////////////////////////////////////////////////////////////////////
  // Drain control
  ////////////////////////////////////////////////////////////////////////////

  // Same round-robin order as issue, so results leave in input order
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= COLL_IDLE;
      ptr             <= '0;
      out_cnt         <= '0;
      take_q          <= '0;
      data_out_enable <= 1'b0;
      ready           <= 1'b0;
    end else begin
      take_q          <= '0;
      data_out_enable <= 1'b0;
      ready           <= 1'b0;
      case (state)
        COLL_IDLE: begin
          if (job_start) begin
            ptr     <= '0;
            out_cnt <= '0;
            state   <= COLL_DRAIN;
          end
        end
        COLL_DRAIN: begin
          if (hit) begin
            // take and data_out_enable share a cycle
            take_q[ptr]     <= 1'b1;
            data_out_enable <= 1'b1;
            ptr             <= (ptr == PTR_W'(LANES - 1)) ? '0 : ptr + 1'b1;
            out_cnt         <= out_cnt + 1'b1;
            // Last element of the job
            if (out_cnt == job_size - INDEX_SIZE'(1)) begin
              ready <= 1'b1;
              state <= COLL_IDLE;
            end
          end
        end
        default: state <= COLL_IDLE;
      endcase
    end
  end

  // Result register
  always_ff @(posedge CLK) begin
    if (hit)
      data_out <= result_arr[ptr];
  end

endmodule

//--- design/ntm_vector_divider.sv
// Top level of the vector modular divider: dispatcher, lane array and collector

`timescale 1ns/10ps

module ntm_vector_divider #(
  parameter int DATA_SIZE  = ntm_config_pkg::DEFAULT_DATA_SIZE,
  parameter int INDEX_SIZE = ntm_config_pkg::DEFAULT_INDEX_SIZE,
  parameter int LANES      = ntm_config_pkg::DEFAULT_LANES
) (
  // Global
  input  logic                  CLK,
  input  logic                  RST,

  // Job control
  input  logic                  start,
  input  logic [INDEX_SIZE-1:0] size_in,
  output logic                  ready,

  // Operands
  input  logic [DATA_SIZE-1:0]  modulo_in,
  input  logic [DATA_SIZE-1:0]  data_a_in,
  input  logic                  data_a_in_enable,
  input  logic [DATA_SIZE-1:0]  data_b_in,
  input  logic                  data_b_in_enable,
  output logic                  in_ready,

  // Results, one enable pulse each
  output logic [DATA_SIZE-1:0]  data_out,
  output logic                  data_out_enable
);

  // Job handoff from issue side to drain side
  logic                  job_start;
  logic [INDEX_SIZE-1:0] job_size;

  // One bundle per lane
  lane_if #(.DATA_SIZE(DATA_SIZE)) lanes [LANES] ();

  ////////////////////////////////////////////////////////////////////////////
  // Issue side
  ////////////////////////////////////////////////////////////////////////////

  ntm_vector_dispatcher #(
    .DATA_SIZE  (DATA_SIZE),
    .INDEX_SIZE (INDEX_SIZE),
    .LANES      (LANES)
  ) u_dispatcher (
    .CLK              (CLK),
    .RST              (RST),
    .start            (start),
    .size_in          (size_in),
    .modulo_in        (modulo_in),
    .data_a_in        (data_a_in),
    .data_a_in_enable (data_a_in_enable),
    .data_b_in        (data_b_in),
    .data_b_in_enable (data_b_in_enable),
    .in_ready         (in_ready),
    .job_start        (job_start),
    .job_size         (job_size),
    .lanes            (lanes)
  );

  // Identical scalar lanes
  for (genvar i = 0; i < LANES; i++) begin : g_lane
    ntm_scalar_divider #(
      .DATA_SIZE (DATA_SIZE)
    ) u_scalar_divider (
      .CLK  (CLK),
      .RST  (RST),
      .lane (lanes[i])
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // Drain side
  ////////////////////////////////////////////////////////////////////////////

  ntm_vector_collector #(
    .DATA_SIZE  (DATA_SIZE),
    .INDEX_SIZE (INDEX_SIZE),
    .LANES      (LANES)
  ) u_collector (
    .CLK             (CLK),
    .RST             (RST),
    .job_start       (job_start),
    .job_size        (job_size),
    .lanes           (lanes),
    .data_out        (data_out),
    .data_out_enable (data_out_enable),
    .ready           (ready)
  );

endmodule

//--- tb/ntm_vector_divider_properties.sv
// Concurrent checks on the vector divider handshake, bound into the top level

`timescale 1ns/10ps

module ntm_vector_divider_properties #(
  parameter int DATA_SIZE = ntm_config_pkg::DEFAULT_DATA_SIZE,
  parameter int LANES     = ntm_config_pkg::DEFAULT_LANES
) (
  input logic                 CLK,
  input logic                 RST,
  input logic                 in_ready,
  input logic                 data_out_enable,
  input logic                 ready,
  input logic                 have_a,
  input logic                 have_b,
  input logic [DATA_SIZE-1:0] hold_a,
  input logic [DATA_SIZE-1:0] hold_b
);

  // Failed assertions so far, polled by the testbench
  int fail_count = 0;

  ////////////////////////////////////////////////////////////////////////////
  // Output side
  ////////////////////////////////////////////////////////////////////////////

  // Job end marks the last result
  ready_with_result: assert property (
    @(posedge CLK) disable iff (RST) ready |-> data_out_enable
  ) else begin
    $error("ready without data_out_enable");
    fail_count++;
  end

  // Lane count bounds a burst of back to back results
  result_burst: assert property (
    @(posedge CLK) disable iff (RST) data_out_enable [*LANES] |=> !data_out_enable
  ) else begin
    $error("more than LANES results in consecutive cycles");
    fail_count++;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Input side
  ////////////////////////////////////////////////////////////////////////////

  // No job active straight out of reset
  in_ready_reset: assert property (
    @(posedge CLK) (RST || $fell(RST)) |-> !in_ready
  ) else begin
    $error("in_ready high during or right after reset");
    fail_count++;
  end

  // Refused operands leave the held pair alone
  no_capture_flag: assert property (
    @(posedge CLK) disable iff (RST) !in_ready |=> !$rose(have_a) && !$rose(have_b)
  ) else begin
    $error("operand flag set while in_ready low");
    fail_count++;
  end

  no_capture_a: assert property (
    @(posedge CLK) disable iff (RST) (!in_ready && have_a) |=> $stable(hold_a)
  ) else begin
    $error("held A changed while in_ready low");
    fail_count++;
  end

  no_capture_b: assert property (
    @(posedge CLK) disable iff (RST) (!in_ready && have_b) |=> $stable(hold_b)
  ) else begin
    $error("held B changed while in_ready low");
    fail_count++;
  end

endmodule

bind ntm_vector_divider ntm_vector_divider_properties #(
  .DATA_SIZE (DATA_SIZE),
  .LANES     (LANES)
) u_properties (
  .CLK             (CLK),
  .RST             (RST),
  .in_ready        (in_ready),
  .data_out_enable (data_out_enable),
  .ready           (ready),
  .have_a          (u_dispatcher.have_a),
  .have_b          (u_dispatcher.have_b),
  .hold_a          (u_dispatcher.hold_a),
  .hold_b          (u_dispatcher.hold_b)
);

//--- tb/ntm_vector_divider_tb.sv
// Testbench for the vector modular divider with clock, reset, job table, reference model and checks

`timescale 1ns/10ps

module ntm_vector_divider_tb;

  import ntm_config_pkg::*;

  localparam int DATA_SIZE  = DEFAULT_DATA_SIZE;
  localparam int INDEX_SIZE = DEFAULT_INDEX_SIZE;
  localparam int LANES      = DEFAULT_LANES;

  // Table capacity
  localparam int MAX_JOBS  = 16;
  localparam int MAX_ELEMS = 64;

  // Cycle limits generous against one lane latency
  localparam int JOB_TIMEOUT = 40 * (2 * DATA_SIZE + 2);
  localparam int IDLE_CYCLES = 6;

  logic                  CLK;
  logic                  RST;
  logic                  start;
  logic [INDEX_SIZE-1:0] size_in;
  logic [DATA_SIZE-1:0]  modulo_in;
  logic [DATA_SIZE-1:0]  data_a_in;
  logic                  data_a_in_enable;
  logic [DATA_SIZE-1:0]  data_b_in;
  logic                  data_b_in_enable;
  logic                  in_ready;
  logic [DATA_SIZE-1:0]  data_out;
  logic                  data_out_enable;
  logic                  ready;

  // Job table with the size as presented on size_in
  string job_name    [MAX_JOBS];
  int    job_size    [MAX_JOBS];
  int    job_first   [MAX_JOBS];
  int    job_restart [MAX_JOBS];
  int    job_count;

  // Element table of divisor, dividend, modulus and presentation mode
  // Mode 0 pairs A and B, mode 1 sends A first, mode 2 sends B first
  logic [DATA_SIZE-1:0] el_a    [MAX_ELEMS];
  logic [DATA_SIZE-1:0] el_b    [MAX_ELEMS];
  logic [DATA_SIZE-1:0] el_m    [MAX_ELEMS];
  int                   el_mode [MAX_ELEMS];
  int                   el_count;

  integer seed;
  int     j;

  ntm_vector_divider #(
    .DATA_SIZE  (DATA_SIZE),
    .INDEX_SIZE (INDEX_SIZE),
    .LANES      (LANES)
  ) uut (
    .CLK              (CLK),
    .RST              (RST),
    .start            (start),
    .size_in          (size_in),
    .ready            (ready),
    .modulo_in        (modulo_in),
    .data_a_in        (data_a_in),
    .data_a_in_enable (data_a_in_enable),
    .data_b_in        (data_b_in),
    .data_b_in_enable (data_b_in_enable),
    .in_ready         (in_ready),
    .data_out         (data_out),
    .data_out_enable  (data_out_enable)
  );

  always #5 CLK = ~CLK;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and table helpers
  ////////////////////////////////////////////////////////////////////////////

  // Quotient of b by a reduced by m unless m is zero
  function automatic logic [DATA_SIZE-1:0] modular_quotient(
    input logic [DATA_SIZE-1:0] a,
    input logic [DATA_SIZE-1:0] b,
    input logic [DATA_SIZE-1:0] m
  );
    logic [DATA_SIZE-1:0] q;
    if (a == '0)
      return '0;
    q = b / a;
    if (m != '0)
      q = q % m;
    return q;
  endfunction

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic add_job(input string name, input int size, input int restart);
    job_name[job_count]    = name;
    job_size[job_count]    = size;
    job_first[job_count]   = el_count;
    job_restart[job_count] = restart;
    job_count++;
  endtask

  task automatic add_elem(input int a, input int b, input int m, input int mode);
    el_a[el_count]    = DATA_SIZE'(a);
    el_b[el_count]    = DATA_SIZE'(b);
    el_m[el_count]    = DATA_SIZE'(m);
    el_mode[el_count] = mode;
    el_count++;
  endtask

  task automatic build_table();
    int i;
    int r_a;
    int r_b;
    int r_m;
    int r_mode;
    job_count = 0;
    el_count  = 0;
    // Single elements with ordinary, zero divisor and zero modulus cases
    add_job("single_ordinary", 1, 0);
    add_elem(7, 100, 5, 0);
    add_job("single_zero_divisor", 1, 0);
    add_elem(0, 1234, 9, 0);
    add_job("single_zero_modulus", 1, 0);
    add_elem(3, 1000, 0, 0);
    // Longer than the lane count with pairs back to back
    add_job("long_back_to_back", 2 * LANES + 2, 0);
    for (i = 0; i < 2 * LANES + 2; i++)
      add_elem(3 * i + 1, 60000 - 4099 * i, (i % 4 == 0) ? 0 : 7 * i + 5, 0);
    // A and B on separate cycles in both orders
    add_job("split_operands", 4, 0);
    add_elem(5, 77, 6, 1);
    add_elem(9, 65535, 100, 2);
    add_elem(400, 300, 7, 1);
    add_elem(13, 4000, 0, 2);
    // Zero length means one element
    add_job("size_zero", 0, 0);
    add_elem(6, 500, 11, 0);
    // Extra start pulses while busy
    add_job("start_during_job", 5, 5);
    for (i = 0; i < 5; i++)
      add_elem(i + 2, 1000 * i + 999, 3 + i, 0);
    add_job("random_rows", 12, 0);
    for (i = 0; i < 12; i++) begin
      r_a    = $random(seed) & 32'h00ff;
      r_b    = $random(seed) & 32'hffff;
      r_m    = $random(seed) & 32'h003f;
      r_mode = ($random(seed) & 32'h7fff) % 3;
      add_elem(r_a, r_b, r_m, r_mode);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Job execution
  ////////////////////////////////////////////////////////////////////////////

  // Drive and sample on falling edges until the last result
  task automatic run_job(input int jb);
    int n;
    int k;
    int fed;
    int got;
    int cycles;
    bit have_a;
    bit have_b;
    bit send_a;
    bit send_b;
    bit finished;
    logic [DATA_SIZE-1:0] expected;
    n        = (job_size[jb] == 0) ? 1 : job_size[jb];
    fed      = 0;
    got      = 0;
    cycles   = 0;
    have_a   = 1'b0;
    have_b   = 1'b0;
    finished = 1'b0;
    start    = 1'b1;
    size_in  = INDEX_SIZE'(job_size[jb]);
    @(negedge CLK);
    while (!finished) begin
      // Results in input order
      if (data_out_enable) begin
        k        = job_first[jb] + got;
        expected = modular_quotient(el_a[k], el_b[k], el_m[k]);
        assert (data_out === expected) else begin
          $display("[FAIL] %s result %0d: expected %0d, actual %0d",
                   job_name[jb], got, expected, data_out);
          abort_run();
        end
        got++;
        finished = (got == n);
      end
      assert (ready === (data_out_enable && finished)) else begin
        $display("[FAIL] %s ready after %0d results: expected %0b, actual %0b",
                 job_name[jb], got, data_out_enable && finished, ready);
        abort_run();
      end
      assert (uut.u_properties.fail_count == 0) else begin
        $display("A concurrent assertion failed during job %s", job_name[jb]);
        abort_run();
      end
      start = (job_restart[jb] != 0) &&
              (cycles == job_restart[jb] || cycles == 4 * job_restart[jb]);
      data_a_in_enable = 1'b0;
      data_b_in_enable = 1'b0;
      // Newest complete pair is the next one issued
      if (fed > 0)
        modulo_in = el_m[job_first[jb] + fed - 1];
      if (fed < n && in_ready) begin
        k         = job_first[jb] + fed;
        // Inverted data on a disabled bus
        data_a_in = ~el_a[k];
        data_b_in = ~el_b[k];
        send_a    = (el_mode[k] != 2 && !have_a) || (el_mode[k] == 2 && have_b);
        send_b    = (el_mode[k] != 1 && !have_b) || (el_mode[k] == 1 && have_a);
        if (send_a) begin
          data_a_in        = el_a[k];
          data_a_in_enable = 1'b1;
          have_a           = 1'b1;
        end
        if (send_b) begin
          data_b_in        = el_b[k];
          data_b_in_enable = 1'b1;
          have_b           = 1'b1;
        end
        if (have_a && have_b) begin
          fed++;
          have_a = 1'b0;
          have_b = 1'b0;
        end
      end else if (!in_ready && fed > 0) begin
        // Offers while refused carry the inverse of the held pair
        k                = job_first[jb] + fed - 1;
        data_a_in        = ~el_a[k];
        data_b_in        = ~el_b[k];
        data_a_in_enable = 1'b1;
        data_b_in_enable = 1'b1;
      end
      if (!finished) begin
        @(negedge CLK);
        cycles++;
        assert (cycles < JOB_TIMEOUT) else begin
          $display("Timeout in job %s: %0d of %0d results after %0d cycles",
                   job_name[jb], got, n, cycles);
          abort_run();
        end
      end
    end
    start            = 1'b0;
    data_a_in_enable = 1'b0;
    data_b_in_enable = 1'b0;
  endtask

  // Quiet period that also lets every lane drop busy before the next start
  task automatic idle_check(input int jb);
    int i;
    for (i = 0; i < IDLE_CYCLES; i++) begin
      @(negedge CLK);
      assert (!data_out_enable && !ready && !in_ready) else begin
        $display("Unexpected activity after job %s ended", job_name[jb]);
        abort_run();
      end
    end
  endtask

  initial begin
    CLK              = 1'b0;
    RST              = 1'b1;
    start            = 1'b0;
    size_in          = '0;
    modulo_in        = '0;
    data_a_in        = '0;
    data_a_in_enable = 1'b0;
    data_b_in        = '0;
    data_b_in_enable = 1'b0;
    seed             = 65706;
    build_table();
    repeat (4) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
    @(negedge CLK);
    assert (!ready && !data_out_enable && !in_ready) else begin
      $display("Outputs not low after reset");
      abort_run();
    end
    for (j = 0; j < job_count; j++) begin
      run_job(j);
      idle_check(j);
    end
    if (uut.u_properties.fail_count == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      $display("TEST FAILED");
      $fatal(1, "Concurrent assertion failures recorded");
    end
  end

endmodule

//--- src.f
design/ntm_config_pkg.sv
design/ntm_state_pkg.sv
design/lane_if.sv
design/ntm_scalar_divider.sv
design/ntm_vector_dispatcher.sv
design/ntm_vector_collector.sv
design/ntm_vector_divider.sv
tb/ntm_vector_divider_properties.sv
tb/ntm_vector_divider_tb.sv
